// ==== compile.f ====
+incdir+.
mpu_pkg.sv
mpu_pit.sv
mpu_pic.sv
mpu_rsp_merge.sv
mpu_periph.sv
mpu_tb_clk.sv
mpu_assertions.sv
mpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the peripheral cluster testbench

VERILATOR ?= verilator
TOP       ?= mpu_tb
RTL_TOP   ?= mpu_periph
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mpu_tb.sv ====
`timescale 1ns/10ps
`include "mpu_settings.svh"

// testbench top that acts as the cpu on the peripheral bus
module mpu_tb import mpu_pkg::*; ();

	localparam int          TIMEOUT = 100;	// cycles per wait
	localparam logic [15:0] PIT     = `MPU_PIT_BASE;
	localparam logic [15:0] PIC     = `MPU_PIC_BASE;

	logic                         clk;
	logic                         rst;
	bus_req_t                     req;
	bus_rsp_t                     rsp;
	logic [`MPU_EXT_SOURCES-1:0]  irq_src;
	logic                         irq;
	logic [4:0]                   cause;
	logic [`MPU_PIT_COUNTERS-1:0] pit_out;
	int                           errors = 0;
	int                           test_errs = 0;	// errors and assertion failures so far
	int                           failed_tests = 0;
	int                           pulse_at[$];	// cycle index of each timer pulse

	mpu_tb_clk u_clk (.clk_o(clk), .rst_o(rst));

	mpu_periph u_mpu_periph (
		.clk_i     (clk),
		.rst_i     (rst),
		.req_i     (req),
		.rsp_o     (rsp),
		.irq_src_i (irq_src),
		.irq_o     (irq),
		.cause_o   (cause),
		.pit_out_o (pit_out)
	);

	// ==================================================
	// helpers
	// ==================================================
	task automatic give_up(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$finish;
	endtask

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic logic [15:0] pit_adr(input logic [1:0] k, input logic [1:0] r);
		return PIT | {12'd0, k, r};	// counter k at offset 4k
	endfunction

	function automatic logic [15:0] pic_adr(input logic [3:0] offs);
		return PIC | {12'd0, offs};
	endfunction

	function automatic int lowest_set(input logic [31:0] m);
		for (int i = 0; i < 32; i++)
			if (m[5'(i)])
				return i;
		return 0;
	endfunction

	// one bus cycle with a single-cycle strobe then a wait for ack
	task automatic bus_xfer(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat, output logic err);
		int n;
		@(negedge clk);
		req = '{stb: 1'b1, we: we, adr: adr, dat: wdat};
		@(negedge clk);
		req.stb = 1'b0;
		n = 0;
		while (!rsp.ack && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!rsp.ack)
			give_up("timeout: no ack from the peripheral bus");
		else begin
			rdat = rsp.dat;
			err  = rsp.err;
		end
	endtask

	task automatic bus_write(input logic [15:0] adr, input logic [31:0] wdat);
		logic [31:0] rdat;
		logic        err;
		bus_xfer(1'b1, adr, wdat, rdat, err);
		expect_eq({31'd0, err}, 32'd0, "error flag on mapped write");
	endtask

	task automatic bus_read(input logic [15:0] adr, output logic [31:0] rdat);
		logic err;
		bus_xfer(1'b0, adr, 32'd0, rdat, err);
		expect_eq({31'd0, err}, 32'd0, "error flag on mapped read");
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!irq && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!irq)
			give_up("timeout: irq_o never went high");
	endtask

	// watch one timer output for a fixed window
	task automatic record_pulses(input logic [1:0] k, input int cycles);
		pulse_at.delete();
		for (int i = 1; i <= cycles; i++) begin
			@(negedge clk);
			if (pit_out[k])
				pulse_at.push_back(i);
		end
	endtask

	task automatic end_test(input string name);
		int total;
		total = errors + u_mpu_periph.u_mpu_assertions.fail_cnt;
		if (total == test_errs)
			$display("test %s: ok", name);
		else begin
			$display("test %s: FAILED with %0d errors", name, total - test_errs);
			failed_tests++;
		end
		test_errs = total;
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		logic [31:0] v;
		logic [31:0] mask;
		logic [31:0] rd;
		logic [15:0] ua;
		logic [4:0]  d;
		logic        e;
		int          r;
		req     = '0;
		irq_src = '0;
		void'($urandom(32'haf3b_fcba));
		@(negedge clk);
		for (int n = 0; n < TIMEOUT && rst; n++)
			@(negedge clk);
		if (rst)
			give_up("timeout: reset never released");

		for (int k = 0; k < `MPU_PIT_COUNTERS; k++) begin
			v = $urandom;
			bus_write(pit_adr(2'(k), `MPU_PIT_RELOAD), v);
			bus_read(pit_adr(2'(k), `MPU_PIT_RELOAD), rd);
			expect_eq(rd, v, "pit reload readback");
			bus_read(pit_adr(2'(k), `MPU_PIT_COUNT), rd);
			expect_eq(rd, v, "pit count right after reload write");
		end
		v = $urandom;
		bus_write(pic_adr(`MPU_PIC_ENABLE), v);
		bus_read(pic_adr(`MPU_PIC_ENABLE), rd);
		expect_eq(rd, v, "pic enable readback");
		bus_write(pic_adr(`MPU_PIC_ENABLE), 32'd0);
		end_test("register access");

		do
			ua = 16'($urandom);
		while (ua[15:4] == PIT[15:4] || ua[15:4] == PIC[15:4]);
		bus_xfer(1'b0, ua, 32'd0, rd, e);
		expect_eq({31'd0, e}, 32'd1, "unmapped read error flag");
		expect_eq(rd, 32'd0, "unmapped read data");
		bus_xfer(1'b1, ua, $urandom, rd, e);
		expect_eq({31'd0, e}, 32'd1, "unmapped write error flag");
		end_test("unmapped access");

		// write lands one edge before the top ack, so the pulse shows r - 1 cycles on
		r = 3 + int'($urandom % 10);
		bus_write(pit_adr(2'd2, `MPU_PIT_RELOAD), 32'(r));
		bus_write(pit_adr(2'd2, `MPU_PIT_CTRL), 32'd1);
		record_pulses(2'd2, r + 10);
		expect_eq(pulse_at.size(), 1, "one-shot pulse count");
		if (pulse_at.size() > 0)
			expect_eq(pulse_at[0], r - 1, "one-shot pulse delay");
		bus_read(pit_adr(2'd2, `MPU_PIT_CTRL), rd);
		expect_eq(rd, 32'd0, "one-shot control after expiry");
		end_test("one-shot timer");

		r = 3 + int'($urandom % 6);
		bus_write(pit_adr(2'd1, `MPU_PIT_RELOAD), 32'(r));
		bus_write(pit_adr(2'd1, `MPU_PIT_CTRL), 32'd3);	// enable plus auto-reload
		record_pulses(2'd1, 4 * r);
		bus_write(pit_adr(2'd1, `MPU_PIT_CTRL), 32'd0);
		expect_eq(pulse_at.size(), 4, "auto-reload pulse count");
		for (int i = 1; i < pulse_at.size(); i++)
			expect_eq(pulse_at[i] - pulse_at[i - 1], r, "auto-reload interval");
		end_test("auto-reload");

		mask = '0;
		for (int i = 0; i < 4; i++) begin
			d = 5'($urandom % 29);
			mask[d] = 1'b1;
		end
		d = 5'($urandom % 29);	// one disabled source
		while (mask[d])
			d = (d == 5'd28) ? 5'd0 : d + 5'd1;
		bus_write(pic_adr(`MPU_PIC_ENABLE), mask);
		@(negedge clk);
		irq_src = mask[28:0] | (29'd1 << d);
		wait_irq();
		irq_src = '0;
		expect_eq({27'd0, cause}, 32'(lowest_set(mask)), "cause with several sources");
		bus_read(pic_adr(`MPU_PIC_PENDING), rd);
		expect_eq(rd & 32'h1fff_ffff, mask | (32'd1 << d), "pending external bits");
		for (int i = 0; i < 29; i++) begin
			if (mask[5'(i)]) begin
				bus_write(pic_adr(`MPU_PIC_CLEAR), 32'(i));
				mask[5'(i)] = 1'b0;
				if (mask != 32'd0)
					expect_eq({27'd0, cause}, 32'(lowest_set(mask)), "cause after clear");
			end
		end
		expect_eq({31'd0, irq}, 32'd0, "irq_o after last clear");
		bus_write(pic_adr(`MPU_PIC_CLEAR), {27'd0, d});
		end_test("interrupt priority and clear");

		bus_write(pic_adr(`MPU_PIC_CLEAR), 32'd31);
		bus_write(pic_adr(`MPU_PIC_ENABLE), 32'h8000_0000);	// only the counter 0 source
		expect_eq({31'd0, irq}, 32'd0, "irq_o before timer expiry");
		bus_write(pit_adr(2'd0, `MPU_PIT_RELOAD), 32'd5);
		bus_write(pit_adr(2'd0, `MPU_PIT_CTRL), 32'd1);
		wait_irq();
		expect_eq({27'd0, cause}, 32'd31, "cause for counter 0 expiry");
		bus_write(pic_adr(`MPU_PIC_CLEAR), 32'd31);
		expect_eq({31'd0, irq}, 32'd0, "irq_o after clearing source 31");
		bus_write(pic_adr(`MPU_PIC_ENABLE), 32'd0);
		end_test("timer into controller");

		errors += u_mpu_periph.u_mpu_assertions.fail_cnt;
		$display("tests: 6, failed: %0d, errors: %0d, assertion failures: %0d",
			failed_tests, errors, u_mpu_periph.u_mpu_assertions.fail_cnt);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== mpu_assertions.sv ====
`timescale 1ns/10ps

// bus and interrupt checker bound into the cluster top
module mpu_assertions import mpu_pkg::*; (
	input logic        clk_i,
	input logic        rst_i,
	input bus_req_t    req_i,
	input bus_rsp_t    rsp_i,
	input logic        irq_i,
	input logic [4:0]  cause_i,
	input logic [31:0] enable_i,	// pic enable mask
	input logic [31:0] pending_i	// pic pending bits
);

	int          fail_cnt = 0;	// failed assertions so far
	logic [31:0] active_d;		// the set irq and cause were built from

	always_ff @(posedge clk_i) begin
		if (rst_i)
			active_d <= '0;
		else
			active_d <= enable_i & pending_i;
	end

	// ==================================================
	// response timing
	// ==================================================
	ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		$past(req_i.stb, 2) |-> rsp_i.ack)
	else begin
		$error("strobe not acked two edges later");
		fail_cnt++;
	end

	ack_needs_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		rsp_i.ack |-> $past(req_i.stb, 2))
	else begin
		$error("ack without a strobe two edges earlier");
		fail_cnt++;
	end

	ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
		rsp_i.ack |-> !$past(rsp_i.ack))	// master never strobes back to back
	else begin
		$error("ack lasted more than one cycle");
		fail_cnt++;
	end

	// ==================================================
	// error reply and interrupt consistency
	// ==================================================
	err_zero: assert property (@(posedge clk_i) disable iff (rst_i)
		rsp_i.err |-> (rsp_i.ack && rsp_i.dat == 32'd0))
	else begin
		$error("error reply without ack or with data");
		fail_cnt++;
	end

	irq_cause: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_i |-> active_d[cause_i])	// cause bit enabled and pending
	else begin
		$error("irq raised for a source not enabled and pending");
		fail_cnt++;
	end

endmodule

bind mpu_periph mpu_assertions u_mpu_assertions (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.req_i     (req_i),
	.rsp_i     (rsp_o),
	.irq_i     (irq_o),
	.cause_i   (cause_o),
	.enable_i  (u_pic.enable_q),
	.pending_i (u_pic.pending_q)
);

// ==== mpu_tb_clk.sv ====
`timescale 1ns/10ps

// testbench clock and reset source
module mpu_tb_clk #(
	parameter int HALF_NS    = 2,	// 4 ns period
	parameter int RST_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;	// drops right after the 4th rising edge
	end

endmodule

// ==== mpu_periph.sv ====
`timescale 1ns/10ps
`include "mpu_settings.svh"

// peripheral cluster top
// window decode, strobe gating, timer block, interrupt controller, merger
module mpu_periph import mpu_pkg::*; (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  bus_req_t                     req_i,
	output bus_rsp_t                     rsp_o,
	input  logic [`MPU_EXT_SOURCES-1:0]  irq_src_i,	// external sources 0..28
	output logic                         irq_o,
	output logic [4:0]                   cause_o,
	output logic [`MPU_PIT_COUNTERS-1:0] pit_out_o
);

	localparam logic [15:0] PIT_BASE = `MPU_PIT_BASE;
	localparam logic [15:0] PIC_BASE = `MPU_PIC_BASE;
	localparam int          WB       = `MPU_WIN_BITS;

	logic       cs_pit;
	logic       cs_pic;
	logic       unmapped;
	bus_req_t   pit_req;
	bus_req_t   pic_req;
	slave_rsp_t pit_rsp;
	slave_rsp_t pic_rsp;
	logic [`MPU_IRQ_SOURCES-1:0] pic_src;

	// ==================================================
	// chip selects, 16-word windows
	// ==================================================
	assign cs_pit   = (req_i.adr[15:WB] == PIT_BASE[15:WB]);
	assign cs_pic   = (req_i.adr[15:WB] == PIC_BASE[15:WB]);
	assign unmapped = req_i.stb & ~cs_pit & ~cs_pic;	// gets the error reply

	// each slave only sees its own strobe
	always_comb begin
		pit_req     = req_i;
		pit_req.stb = req_i.stb & cs_pit;
		pic_req     = req_i;
		pic_req.stb = req_i.stb & cs_pic;
	end

	// timer outputs on the top three sources
	// counter 0 is the time slice on 31
	assign pic_src = {pit_out_o[0], pit_out_o[1], pit_out_o[2], irq_src_i};

	mpu_pit u_pit (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.req_i     (pit_req),
		.rsp_o     (pit_rsp),
		.pit_out_o (pit_out_o)
	);

	mpu_pic u_pic (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.req_i   (pic_req),
		.rsp_o   (pic_rsp),
		.src_i   (pic_src),
		.irq_o   (irq_o),
		.cause_o (cause_o)
	);

	mpu_rsp_merge u_rsp_merge (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.pit_rsp_i  (pit_rsp),
		.pic_rsp_i  (pic_rsp),
		.unmapped_i (unmapped),
		.rsp_o      (rsp_o)
	);

endmodule

// ==== mpu_rsp_merge.sv ====
`timescale 1ns/10ps

// response merger
// one registered bus response out of the slave replies
module mpu_rsp_merge import mpu_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  slave_rsp_t pit_rsp_i,
	input  slave_rsp_t pic_rsp_i,
	input  logic       unmapped_i,	// strobe that hit no window
	output bus_rsp_t   rsp_o
);

	logic        unmapped_q;	// lined up with the slave replies
	logic [31:0] dat_nx;

	// unmapped flag takes one edge, same as a slave
	always_ff @(posedge clk_i) begin
		if (rst_i)
			unmapped_q <= 1'b0;
		else
			unmapped_q <= unmapped_i;
	end

	// ==================================================
	// data select, pic over pit
	// ==================================================
	always_comb begin
		if (pic_rsp_i.ack)
			dat_nx = pic_rsp_i.dat;
		else if (pit_rsp_i.ack)
			dat_nx = pit_rsp_i.dat;
		else
			dat_nx = '0;	// error reply carries 0
	end

	// ack is the OR of every source
	always_ff @(posedge clk_i) begin
		rsp_o.dat <= dat_nx;
		if (rst_i) begin
			rsp_o.ack <= 1'b0;
			rsp_o.err <= 1'b0;
		end else begin
			rsp_o.ack <= pic_rsp_i.ack | pit_rsp_i.ack | unmapped_q;
			rsp_o.err <= unmapped_q;
		end
	end

endmodule

// ==== mpu_pic.sv ====
`timescale 1ns/10ps
`include "mpu_settings.svh"

// interrupt controller
// edge latched sources, enable mask, lowest index wins
module mpu_pic import mpu_pkg::*; (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  bus_req_t                            req_i,	// stb already gated
	output slave_rsp_t                          rsp_o,
	input  logic [`MPU_IRQ_SOURCES-1:0]         src_i,
	output logic                                irq_o,
	output logic [$clog2(`MPU_IRQ_SOURCES)-1:0] cause_o
);

	localparam int NSRC = `MPU_IRQ_SOURCES;
	localparam int CW   = $clog2(`MPU_IRQ_SOURCES);

	logic [NSRC-1:0] src_s;		// sampled sources
	logic [NSRC-1:0] src_d;		// one cycle older copy
	logic [NSRC-1:0] rise;		// rising edges this cycle
	logic [NSRC-1:0] enable_q;
	logic [NSRC-1:0] pending_q;
	logic [NSRC-1:0] clr_mask;
	logic [NSRC-1:0] active;	// pending and enabled
	logic [CW-1:0]   cause_nx;
	logic [`MPU_WIN_BITS-1:0] offs;
	logic            wr_en;
	logic            wr_clr;
	logic [31:0]     rd_dat;

	assign offs   = req_i.adr[`MPU_WIN_BITS-1:0];
	assign wr_en  = req_i.stb && req_i.we && (offs == `MPU_PIC_ENABLE);
	assign wr_clr = req_i.stb && req_i.we && (offs == `MPU_PIC_CLEAR);

	// ==================================================
	// edge detect and pending
	// ==================================================
	assign rise     = src_s & ~src_d;
	assign clr_mask = wr_clr ? (NSRC'(1) << req_i.dat[CW-1:0]) : '0;
	assign active   = pending_q & enable_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			src_s     <= '0;
			src_d     <= '0;
			pending_q <= '0;
			enable_q  <= '0;
		end else begin
			src_s <= src_i;
			src_d <= src_s;
			// new edge beats its own clear
			pending_q <= (pending_q & ~clr_mask) | rise;
			if (wr_en)
				enable_q <= req_i.dat;
		end
	end

	// ==================================================
	// priority encoder
	// ==================================================
	always_comb begin
		cause_nx = '0;	// 0 when idle
		for (int i = NSRC - 1; i >= 0; i--) begin
			if (active[i])
				cause_nx = CW'(i);	// downward scan, lowest index ends up here
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			irq_o   <= 1'b0;
			cause_o <= '0;
		end else begin
			irq_o   <= |active;
			cause_o <= cause_nx;
		end
	end

	// ==================================================
	// bus side
	// ==================================================
	always_comb begin
		case (offs)
			`MPU_PIC_ENABLE:  rd_dat = enable_q;
			`MPU_PIC_PENDING: rd_dat = pending_q;
			`MPU_PIC_CAUSE:   rd_dat = {{(32 - CW){1'b0}}, cause_o};
			default:          rd_dat = '0;	// clear reads back 0
		endcase
	end

	always_ff @(posedge clk_i) begin
		rsp_o.dat <= rd_dat;
		if (rst_i)
			rsp_o.ack <= 1'b0;
		else
			rsp_o.ack <= req_i.stb;	// one ack per strobe
	end

endmodule

// ==== mpu_pit.sv ====
`timescale 1ns/10ps
`include "mpu_settings.svh"

// interval timer block
// three down-counters, reload, auto-reload, one-cycle pulse on expiry
module mpu_pit import mpu_pkg::*; (
	input  logic                         clk_i,
	input  logic                         rst_i,
	input  bus_req_t                     req_i,	// stb already gated by the select
	output slave_rsp_t                   rsp_o,
	output logic [`MPU_PIT_COUNTERS-1:0] pit_out_o
);

	localparam int NCNT = `MPU_PIT_COUNTERS;

	logic [31:0]     reload_q [NCNT];	// reload value per counter
	logic [31:0]     count_q [NCNT];	// running count
	logic [NCNT-1:0] en_q;			// counting enabled
	logic [NCNT-1:0] auto_q;		// reload on expiry

	logic [1:0]      sel_idx;	// counter picked by the address
	logic [1:0]      sel_reg;	// register within the counter
	logic            wr_stb;
	logic [NCNT-1:0] wr_reload;
	logic [NCNT-1:0] wr_ctrl;
	logic [31:0]     rd_dat;

	assign sel_idx = req_i.adr[3:2];
	assign sel_reg = req_i.adr[1:0];
	assign wr_stb  = req_i.stb & req_i.we;

	// ==================================================
	// register decode
	// ==================================================
	always_comb begin
		rd_dat = '0;	// unused offsets read 0
		for (int k = 0; k < NCNT; k++) begin
			wr_reload[k] = wr_stb && (sel_idx == 2'(k)) && (sel_reg == `MPU_PIT_RELOAD);
			wr_ctrl[k]   = wr_stb && (sel_idx == 2'(k)) && (sel_reg == `MPU_PIT_CTRL);
			if (sel_idx == 2'(k)) begin
				case (sel_reg)
					`MPU_PIT_RELOAD: rd_dat = reload_q[k];
					`MPU_PIT_COUNT:  rd_dat = count_q[k];
					`MPU_PIT_CTRL:   rd_dat = {30'd0, auto_q[k], en_q[k]};
					default:         rd_dat = '0;
				endcase
			end
		end
	end

	// ==================================================
	// counters
	// ==================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int k = 0; k < NCNT; k++) begin
				reload_q[k] <= '0;
				count_q[k]  <= '0;
			end
			en_q      <= '0;
			auto_q    <= '0;
			pit_out_o <= '0;
		end else begin
			for (int k = 0; k < NCNT; k++) begin
				pit_out_o[k] <= 1'b0;	// pulse lasts one cycle
				if (wr_reload[k]) begin
					reload_q[k] <= req_i.dat;	// bus write wins over the tick
					count_q[k]  <= req_i.dat;
				end else if (en_q[k]) begin
					if (count_q[k] == 32'd1) begin
						pit_out_o[k] <= 1'b1;	// expiry
						count_q[k]   <= auto_q[k] ? reload_q[k] : 32'd0;
					end else if (count_q[k] != 32'd0) begin
						count_q[k] <= count_q[k] - 32'd1;
					end
				end
				// control, one-shot drops enable once it runs out
				if (wr_ctrl[k]) begin
					en_q[k]   <= req_i.dat[0];
					auto_q[k] <= req_i.dat[1];
				end else if (en_q[k] && !auto_q[k] && !wr_reload[k]
						&& count_q[k] <= 32'd1) begin
					en_q[k] <= 1'b0;
				end
			end
		end
	end

	// registered reply, ack one edge after the strobe
	always_ff @(posedge clk_i) begin
		rsp_o.dat <= rd_dat;
		if (rst_i)
			rsp_o.ack <= 1'b0;
		else
			rsp_o.ack <= req_i.stb;
	end

endmodule

// ==== mpu_pkg.sv ====
package mpu_pkg;

	// ==================================================
	// bus types shared by master, decoder and slaves
	// ==================================================

	// one single-word request from the master
	// stb is a one-cycle strobe, no back-pressure
	typedef struct packed {
		logic        stb;	// request strobe
		logic        we;	// 1 = write, 0 = read
		logic [15:0] adr;	// word address
		logic [31:0] dat;	// write data
	} bus_req_t;

	// merged response back to the master
	typedef struct packed {
		logic        ack;	// one cycle per strobe
		logic        err;	// unmapped address
		logic [31:0] dat;	// read data, 0 on error
	} bus_rsp_t;

	// reply of one peripheral
	// ack only when that peripheral was selected
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} slave_rsp_t;

	// widths, handy for checks and casts
	localparam int BUS_REQ_W   = $bits(bus_req_t);	// 50
	localparam int BUS_RSP_W   = $bits(bus_rsp_t);	// 34
	localparam int SLAVE_RSP_W = $bits(slave_rsp_t);	// 33

	// idle values
	localparam bus_req_t   BUS_REQ_IDLE   = '0;
	localparam bus_rsp_t   BUS_RSP_IDLE   = '0;
	localparam slave_rsp_t SLAVE_RSP_IDLE = '0;

endpackage

// ==== mpu_settings.svh ====
`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

// ==================================================
// address map, word addressed, 32-bit data
// ==================================================
`define MPU_WIN_BITS	4		// each peripheral owns 16 words
`define MPU_PIT_BASE	16'h0100	// interval timer window
`define MPU_PIC_BASE	16'h0200	// interrupt controller window

// ==================================================
// interval timer block
// ==================================================
`define MPU_PIT_COUNTERS	3
// counter k sits at offset 4k, low two offset bits pick the register
`define MPU_PIT_RELOAD	2'd0	// r/w, a write also loads the count
`define MPU_PIT_COUNT	2'd1	// read only
`define MPU_PIT_CTRL	2'd2	// bit 0 enable, bit 1 auto-reload

// ==================================================
// interrupt controller
// ==================================================
`define MPU_IRQ_SOURCES	32
`define MPU_EXT_SOURCES	29	// sources 29..31 are the timer outputs
`define MPU_PIC_ENABLE	4'd0	// r/w enable mask
`define MPU_PIC_PENDING	4'd1	// read only
`define MPU_PIC_CLEAR	4'd2	// write only, data[4:0] names the bit
`define MPU_PIC_CAUSE	4'd3	// read only, 0 when nothing active

`endif
